/* Bender.yml */
package:
  name: sobel_accelerator

sources:
  - files:
      - sobelPkg.sv
      - sobelConfigRegs.sv
      - sobelWindowFilter.sv
      - sobelWordFifo.sv
      - sobelBurstWriter.sv
      - sobelAccelerator.sv
  - target: test
    files:
      - tbSobelAccelerator.sv

/* sobelAccelerator.sv */
module sobelAccelerator (
    input  logic              camClock,
    input  logic              rstN,
    input  logic              hsync,
    input  logic              vsync,
    input  logic              validCamera,
    input  sobelPkg::pixelT   camData,
    input  logic              ciStart,
    input  logic [7:0]        ciN,
    input  sobelPkg::busWordT ciValueA,
    input  sobelPkg::busWordT ciValueB,
    output sobelPkg::busWordT ciResult,
    output logic              ciDone,
    output logic              requestBus,
    input  logic              busGrant,
    output logic              beginTransactionOut,
    output sobelPkg::busWordT addressDataOut,
    output logic              endTransactionOut,
    output logic [3:0]        byteEnablesOut,
    output logic              dataValidOut,
    output logic [7:0]        burstSizeOut,
    input  logic              busyIn,
    input  logic              busErrorIn
);

    logic                gradValid;
    sobelPkg::pixelT     gradPixel;
    sobelPkg::fifoCountT wordCount;
    sobelPkg::busWordT   headWord;
    logic                popWord;
    logic                overflowPulse;
    logic                busErrorPulse;
    sobelPkg::busWordT   busStart;
    sobelPkg::burstLenT  burstLen;
    logic                transferEnable;

    sobelConfigRegs cfg0 (
        .camClock(camClock), .rstN(rstN), .ciStart(ciStart), .ciN(ciN),
        .ciValueA(ciValueA), .ciValueB(ciValueB), .overflowPulse(overflowPulse),
        .busErrorPulse(busErrorPulse), .ciResult(ciResult), .ciDone(ciDone),
        .busStart(busStart), .burstLen(burstLen), .transferEnable(transferEnable)
    );

    sobelWindowFilter filter0 (
        .camClock(camClock), .rstN(rstN), .hsync(hsync), .vsync(vsync),
        .validCamera(validCamera), .camData(camData),
        .gradValid(gradValid), .gradPixel(gradPixel)
    );

    sobelWordFifo fifo0 (
        .camClock(camClock), .rstN(rstN), .hsync(hsync), .gradValid(gradValid),
        .gradPixel(gradPixel), .popWord(popWord), .wordCount(wordCount),
        .headWord(headWord), .overflowPulse(overflowPulse)
    );

    sobelBurstWriter writer0 (
        .camClock(camClock), .rstN(rstN), .vsync(vsync), .busStart(busStart),
        .burstLen(burstLen), .transferEnable(transferEnable), .wordCount(wordCount),
        .headWord(headWord), .busGrant(busGrant), .busyIn(busyIn),
        .busErrorIn(busErrorIn), .popWord(popWord), .busErrorPulse(busErrorPulse),
        .requestBus(requestBus), .beginTransactionOut(beginTransactionOut),
        .addressDataOut(addressDataOut), .endTransactionOut(endTransactionOut),
        .byteEnablesOut(byteEnablesOut), .dataValidOut(dataValidOut),
        .burstSizeOut(burstSizeOut)
    );

endmodule

/* sobelBurstWriter.sv */
module sobelBurstWriter (
    input  logic                camClock,
    input  logic                rstN,
    input  logic                vsync,
    input  sobelPkg::busWordT   busStart,
    input  sobelPkg::burstLenT  burstLen,
    input  logic                transferEnable,
    input  sobelPkg::fifoCountT wordCount,
    input  sobelPkg::busWordT   headWord,
    input  logic                busGrant,
    input  logic                busyIn,
    input  logic                busErrorIn,
    output logic                popWord,
    output logic                busErrorPulse,
    output logic                requestBus,
    output logic                beginTransactionOut,
    output sobelPkg::busWordT   addressDataOut,
    output logic                endTransactionOut,
    output logic [3:0]          byteEnablesOut,
    output logic                dataValidOut,
    output logic [7:0]          burstSizeOut
);

    sobelPkg::writerStateE state;
    sobelPkg::writerStateE nextState;
    sobelPkg::burstLenT    remaining;
    sobelPkg::busWordT     busAddr;
    sobelPkg::busWordT     startSeen;
    logic                  reloadPending;
    logic                  reloadNow;
    logic                  startBurst;
    logic                  holdBus;

    assign startBurst = transferEnable && burstLen != '0 && wordCount >= burstLen;
    assign requestBus = state == sobelPkg::stateRequest;
    assign popWord    = state == sobelPkg::stateWrite && !busErrorIn && !busyIn &&
                        remaining != '0;
    assign holdBus    = state == sobelPkg::stateWrite && busyIn && !busErrorIn;

    // New frame or new start address
    assign reloadNow  = reloadPending || vsync || busStart != startSeen;

    always_comb begin
        nextState = state;
        case (state)
            sobelPkg::stateIdle:    if (startBurst) nextState = sobelPkg::stateRequest;
            sobelPkg::stateRequest: if (busGrant) nextState = sobelPkg::stateInit;
            sobelPkg::stateInit:    nextState = sobelPkg::stateWrite;
            sobelPkg::stateWrite: begin
                if (busErrorIn) begin
                    nextState = sobelPkg::stateError;
                end else if (!busyIn && remaining == '0) begin
                    nextState = sobelPkg::stateClose;
                end
            end
            default:                nextState = sobelPkg::stateIdle;
        endcase
    end

    always_ff @(posedge camClock or negedge rstN) begin
        if (!rstN) begin
            state         <= sobelPkg::stateIdle;
            remaining     <= '0;
            busAddr       <= '0;
            startSeen     <= '0;
            reloadPending <= 1'b1;
        end else begin
            state     <= nextState;
            startSeen <= busStart;
            if (state == sobelPkg::stateInit) begin
                remaining <= burstLen;
            end else if (popWord) begin
                remaining <= remaining - 1'b1;
            end
            // Reload waits for idle so a burst keeps its addresses
            if (state == sobelPkg::stateIdle && reloadNow) begin
                busAddr       <= busStart;
                reloadPending <= 1'b0;
            end else begin
                reloadPending <= reloadNow;
                if (popWord) begin
                    busAddr <= busAddr + sobelPkg::wordStride;
                end
            end
        end
    end

    always_ff @(posedge camClock or negedge rstN) begin
        if (!rstN) begin
            beginTransactionOut <= 1'b0;
            endTransactionOut   <= 1'b0;
            byteEnablesOut      <= 4'h0;
            burstSizeOut        <= 8'd0;
            busErrorPulse       <= 1'b0;
            addressDataOut      <= '0;
            dataValidOut        <= 1'b0;
        end else begin
            beginTransactionOut <= state == sobelPkg::stateInit;
            byteEnablesOut      <= (state == sobelPkg::stateInit) ? 4'hf : 4'h0;
            burstSizeOut        <= (state == sobelPkg::stateInit) ?
                                   {3'b000, burstLen} - 8'd1 : 8'd0;
            endTransactionOut   <= state == sobelPkg::stateClose ||
                                   state == sobelPkg::stateError;
            busErrorPulse       <= state == sobelPkg::stateError;
            if (state == sobelPkg::stateInit) begin
                addressDataOut <= busAddr;
                dataValidOut   <= 1'b0;
            end else if (popWord) begin
                addressDataOut <= headWord;
                dataValidOut   <= 1'b1;
            end else if (!holdBus) begin
                addressDataOut <= '0;
                dataValidOut   <= 1'b0;
            end
        end
    end

    assert property (@(posedge camClock) disable iff (!rstN)
        dataValidOut |-> state inside {sobelPkg::stateWrite, sobelPkg::stateClose});

endmodule

/* sobelConfigRegs.sv */
module sobelConfigRegs (
    input  logic                camClock,
    input  logic                rstN,
    input  logic                ciStart,
    input  logic [7:0]          ciN,
    input  sobelPkg::busWordT   ciValueA,
    input  sobelPkg::busWordT   ciValueB,
    input  logic                overflowPulse,
    input  logic                busErrorPulse,
    output sobelPkg::busWordT   ciResult,
    output logic                ciDone,
    output sobelPkg::busWordT   busStart,
    output sobelPkg::burstLenT  burstLen,
    output logic                transferEnable
);

    sobelPkg::cfgRegE regSel;
    logic             validInstr;
    logic             writeInstr;
    logic             overflowFlag;
    logic             busErrorFlag;

    assign validInstr = ciStart && (ciN == sobelPkg::customId);
    assign ciDone     = validInstr;
    assign regSel     = sobelPkg::cfgRegE'(ciValueA[12:10]);
    assign writeInstr = validInstr && ciValueA[9];

    // Reads only, writes answer zero
    always_comb begin
        ciResult = '0;
        if (validInstr && !ciValueA[9]) begin
            case (regSel)
                sobelPkg::regBusStart:       ciResult = busStart;
                sobelPkg::regBurstLen:       ciResult = sobelPkg::busWordT'(burstLen);
                sobelPkg::regTransferEnable: ciResult = sobelPkg::busWordT'(transferEnable);
                sobelPkg::regStatus:         ciResult = {30'd0, overflowFlag, busErrorFlag};
                default:                     ciResult = '0;
            endcase
        end
    end

    always_ff @(posedge camClock or negedge rstN) begin
        if (!rstN) begin
            busStart       <= '0;
            burstLen       <= '0;
            transferEnable <= 1'b0;
            overflowFlag   <= 1'b0;
            busErrorFlag   <= 1'b0;
        end else begin
            if (writeInstr && regSel == sobelPkg::regBusStart) begin
                busStart <= ciValueB;
            end
            if (writeInstr && regSel == sobelPkg::regBurstLen) begin
                burstLen <= ciValueB[$bits(sobelPkg::burstLenT)-1:0];
            end
            if (writeInstr && regSel == sobelPkg::regTransferEnable) begin
                transferEnable <= ciValueB[0];
            end
            // New events in the clearing cycle still stick
            if (writeInstr && regSel == sobelPkg::regStatus) begin
                overflowFlag <= overflowPulse;
                busErrorFlag <= busErrorPulse;
            end else begin
                overflowFlag <= overflowFlag | overflowPulse;
                busErrorFlag <= busErrorFlag | busErrorPulse;
            end
        end
    end

    // The writer never sees an empty or oversized burst
    assert property (@(posedge camClock) disable iff (!rstN)
        transferEnable |-> (burstLen != '0 && burstLen <= sobelPkg::maxBurst));

endmodule

/* sobelPkg.sv */
package sobelPkg;

    // Instruction number decoded by the custom-instruction port
    localparam logic [7:0] customId = 8'h3c;

    localparam int pixelWidth = 8;
    typedef logic [pixelWidth-1:0] pixelT;

    // Lines hold up to 256 pixels
    localparam int lineAddrWidth = 8;

    // Worst case column difference is 4 * 255
    localparam int gradWidth = 11;

    typedef logic [31:0] busWordT;

    localparam int pixelsPerWord = 4;

    localparam int fifoDepth = 64;
    typedef logic [$clog2(fifoDepth):0] fifoCountT;

    localparam int maxBurst = 16;
    typedef logic [$clog2(maxBurst):0] burstLenT;

    // Bytes per bus word
    localparam int wordStride = 4;

    typedef enum logic [2:0] {
        regNone           = 3'd0,
        regBusStart       = 3'd1,
        regBurstLen       = 3'd2,
        regTransferEnable = 3'd3,
        regStatus         = 3'd4
    } cfgRegE;

    typedef enum logic [2:0] {
        stateIdle,
        stateRequest,
        stateInit,
        stateWrite,
        stateClose,
        stateError
    } writerStateE;

endpackage

/* sobelWindowFilter.sv */
module sobelWindowFilter (
    input  logic            camClock,
    input  logic            rstN,
    input  logic            hsync,
    input  logic            vsync,
    input  logic            validCamera,
    input  sobelPkg::pixelT camData,
    output logic            gradValid,
    output sobelPkg::pixelT gradPixel
);

    // Line one above and line two above the current one
    sobelPkg::pixelT lineMemNear [0:2**sobelPkg::lineAddrWidth-1];
    sobelPkg::pixelT lineMemFar  [0:2**sobelPkg::lineAddrWidth-1];

    logic [sobelPkg::lineAddrWidth-1:0] colIdx;
    logic [1:0]                         rowIdx;
    logic                               lineHasPixels;
    logic                               pixelStrobe;

    sobelPkg::pixelT nearPixel;
    sobelPkg::pixelT farPixel;

    // Window columns c-1 and c-2, top row first
    sobelPkg::pixelT midTop;
    sobelPkg::pixelT midMid;
    sobelPkg::pixelT midBot;
    sobelPkg::pixelT leftTop;
    sobelPkg::pixelT leftMid;
    sobelPkg::pixelT leftBot;

    logic [sobelPkg::gradWidth-1:0] rightSum;
    logic [sobelPkg::gradWidth-1:0] leftSum;
    logic [sobelPkg::gradWidth-1:0] gradAbs;

    // A vsync cycle carries no pixel
    assign pixelStrobe = validCamera & ~vsync;

    assign nearPixel = lineMemNear[colIdx];
    assign farPixel  = lineMemFar[colIdx];

    always_ff @(posedge camClock or negedge rstN) begin
        if (!rstN) begin
            colIdx        <= '0;
            rowIdx        <= '0;
            lineHasPixels <= 1'b0;
        end else if (vsync) begin
            colIdx        <= '0;
            rowIdx        <= '0;
            lineHasPixels <= 1'b0;
        end else if (hsync) begin
            colIdx        <= '0;
            lineHasPixels <= 1'b0;
            // First hsync of a frame opens row 0
            if (lineHasPixels && rowIdx != 2'd2) begin
                rowIdx <= rowIdx + 2'd1;
            end
        end else if (pixelStrobe) begin
            colIdx        <= colIdx + 1'b1;
            lineHasPixels <= 1'b1;
        end
    end

    always_ff @(posedge camClock) begin
        if (pixelStrobe) begin
            lineMemNear[colIdx] <= camData;
            lineMemFar[colIdx]  <= nearPixel;
            leftTop <= midTop;
            leftMid <= midMid;
            leftBot <= midBot;
            midTop  <= farPixel;
            midMid  <= nearPixel;
            midBot  <= camData;
        end
    end

    // Right column 1,2,1 against left column 1,2,1
    always_comb begin
        rightSum = farPixel + (nearPixel << 1) + camData;
        leftSum  = leftTop + (leftMid << 1) + leftBot;
        if (rightSum >= leftSum) begin
            gradAbs = rightSum - leftSum;
        end else begin
            gradAbs = leftSum - rightSum;
        end
    end

    always_ff @(posedge camClock or negedge rstN) begin
        if (!rstN) begin
            gradValid <= 1'b0;
        end else begin
            gradValid <= pixelStrobe && rowIdx == 2'd2 && colIdx >= 2;
        end
    end

    always_ff @(posedge camClock) begin
        if (pixelStrobe) begin
            if (|gradAbs[sobelPkg::gradWidth-1:sobelPkg::pixelWidth]) begin
                gradPixel <= '1;
            end else begin
                gradPixel <= gradAbs[sobelPkg::pixelWidth-1:0];
            end
        end
    end

    assert property (@(posedge camClock) disable iff (!rstN) hsync |=> !gradValid);

endmodule

/* sobelWordFifo.sv */
module sobelWordFifo (
    input  logic                camClock,
    input  logic                rstN,
    input  logic                hsync,
    input  logic                gradValid,
    input  sobelPkg::pixelT     gradPixel,
    input  logic                popWord,
    output sobelPkg::fifoCountT wordCount,
    output sobelPkg::busWordT   headWord,
    output logic                overflowPulse
);

    sobelPkg::busWordT fifoMem [0:sobelPkg::fifoDepth-1];
    sobelPkg::pixelT   laneData [0:sobelPkg::pixelsPerWord-2];

    logic [$clog2(sobelPkg::pixelsPerWord)-1:0] lane;
    logic [$clog2(sobelPkg::fifoDepth)-1:0]     wrPtr;
    logic [$clog2(sobelPkg::fifoDepth)-1:0]     rdPtr;

    sobelPkg::busWordT packedWord;
    logic              wordDone;
    logic              fifoFull;
    logic              pushWord;

    assign wordDone = gradValid && lane == sobelPkg::pixelsPerWord - 1;
    assign fifoFull = wordCount == sobelPkg::fifoDepth;
    assign pushWord = wordDone && !fifoFull;
    assign headWord = fifoMem[rdPtr];

    // First pixel lands in the low byte
    always_comb begin
        for (int i = 0; i < sobelPkg::pixelsPerWord - 1; i++) begin
            packedWord[i*sobelPkg::pixelWidth +: sobelPkg::pixelWidth] = laneData[i];
        end
        packedWord[(sobelPkg::pixelsPerWord-1)*sobelPkg::pixelWidth +: sobelPkg::pixelWidth] =
            gradPixel;
    end

    // A pixel in the hsync cycle still completes its word, partial words drop
    always_ff @(posedge camClock or negedge rstN) begin
        if (!rstN) begin
            lane <= '0;
        end else if (hsync) begin
            lane <= '0;
        end else if (gradValid) begin
            lane <= lane + 1'b1;
        end
    end

    always_ff @(posedge camClock) begin
        if (gradValid && !wordDone) begin
            laneData[lane] <= gradPixel;
        end
        if (pushWord) begin
            fifoMem[wrPtr] <= packedWord;
        end
    end

    always_ff @(posedge camClock or negedge rstN) begin
        if (!rstN) begin
            wrPtr         <= '0;
            rdPtr         <= '0;
            wordCount     <= '0;
            overflowPulse <= 1'b0;
        end else begin
            overflowPulse <= wordDone && fifoFull;
            if (pushWord) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (popWord) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({pushWord, popWord})
                2'b10:   wordCount <= wordCount + 1'b1;
                2'b01:   wordCount <= wordCount - 1'b1;
                default: wordCount <= wordCount;
            endcase
        end
    end

    assert property (@(posedge camClock) disable iff (!rstN) popWord |-> wordCount != '0);

endmodule

/* tbSobelAccelerator.sv */
module tbSobelAccelerator;

    localparam int frameWidth = 18;
    localparam int frameLines = 6;
    localparam int burstWords = 4;
    localparam int wordBytes  = 4;
    localparam int waitLimit  = 400;
    localparam sobelPkg::busWordT baseAddr = 32'h2000_0100;

    typedef enum {sigRequest, sigBegin, sigEnd} busSigE;

    logic              camClock;
    logic              rstN;
    logic              hsync;
    logic              vsync;
    logic              validCamera;
    sobelPkg::pixelT   camData;
    logic              ciStart;
    logic [7:0]        ciN;
    sobelPkg::busWordT ciValueA;
    sobelPkg::busWordT ciValueB;
    sobelPkg::busWordT ciResult;
    logic              ciDone;
    logic              requestBus;
    logic              busGrant;
    logic              beginTransactionOut;
    sobelPkg::busWordT addressDataOut;
    logic              endTransactionOut;
    logic [3:0]        byteEnablesOut;
    logic              dataValidOut;
    logic [7:0]        burstSizeOut;
    logic              busyIn;
    logic              busErrorIn;

    integer seed;
    int     errorCount;
    int     checkCount;
    int     testCount;

    sobelPkg::pixelT   pixels [0:7][0:255];
    sobelPkg::busWordT expWords [$];
    sobelPkg::busWordT gotWords [$];
    sobelPkg::busWordT gotAddrs [$];
    sobelPkg::busWordT gotSizes [$];

    sobelAccelerator dut0 (
        .camClock(camClock), .rstN(rstN), .hsync(hsync), .vsync(vsync),
        .validCamera(validCamera), .camData(camData), .ciStart(ciStart), .ciN(ciN),
        .ciValueA(ciValueA), .ciValueB(ciValueB), .ciResult(ciResult), .ciDone(ciDone),
        .requestBus(requestBus), .busGrant(busGrant),
        .beginTransactionOut(beginTransactionOut), .addressDataOut(addressDataOut),
        .endTransactionOut(endTransactionOut), .byteEnablesOut(byteEnablesOut),
        .dataValidOut(dataValidOut), .burstSizeOut(burstSizeOut), .busyIn(busyIn),
        .busErrorIn(busErrorIn)
    );

    always #4 camClock = ~camClock;

    task automatic step();
        @(posedge camClock);
        #1;
    endtask

    task automatic failRun(input string reason);
        $display("Timeout at %0t: %s within %0d cycles", $time, reason, waitLimit);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic checkWord(input string what, input sobelPkg::busWordT got,
                             input sobelPkg::busWordT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkStatus(input sobelPkg::busWordT got, input sobelPkg::busWordT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("FAILED at %0t: status overflow=%b busError=%b, expected %b %b",
                     $time, got[1], got[0], exp[1], exp[0]);
        end
    endtask

    task automatic checkFlag(input string what, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic logic busLevel(input busSigE sig);
        case (sig)
            sigRequest: return requestBus;
            sigBegin:   return beginTransactionOut;
            default:    return endTransactionOut;
        endcase
    endfunction

    task automatic waitFor(input busSigE sig, input string what);
        int n;
        n = 0;
        while (!busLevel(sig)) begin
            if (n == waitLimit) begin
                failRun(what);
            end
            step();
            n++;
        end
    endtask

    task automatic applyReset();
        rstN = 1'b0;
        repeat (16) step();
        rstN = 1'b1;
        step();
    endtask

    // Custom instruction, result sampled mid-cycle
    task automatic ciAccess(input logic [7:0] id, input sobelPkg::cfgRegE sel, input logic wr,
                            input sobelPkg::busWordT value, output sobelPkg::busWordT result,
                            output logic done);
        ciStart  = 1'b1;
        ciN      = id;
        ciValueA = {19'd0, sel, wr, 9'd0};
        ciValueB = value;
        #3;
        result = ciResult;
        done   = ciDone;
        step();
        ciStart  = 1'b0;
        ciN      = 8'd0;
        ciValueA = '0;
        ciValueB = '0;
    endtask

    task automatic writeReg(input sobelPkg::cfgRegE sel, input sobelPkg::busWordT value);
        sobelPkg::busWordT result;
        logic              done;
        ciAccess(sobelPkg::customId, sel, 1'b1, value, result, done);
        checkFlag("ciDone on write", done, 1'b1);
        checkWord("ciResult on write", result, '0);
    endtask

    task automatic readReg(input sobelPkg::cfgRegE sel, output sobelPkg::busWordT value);
        logic done;
        ciAccess(sobelPkg::customId, sel, 1'b0, '0, value, done);
        checkFlag("ciDone on read", done, 1'b1);
    endtask

    task automatic configure(input sobelPkg::busWordT base, input int len, input logic enable);
        writeReg(sobelPkg::regBurstLen, len);
        writeReg(sobelPkg::regBusStart, base);
        writeReg(sobelPkg::regTransferEnable, enable);
    endtask

    task automatic fillFrame(input int width, input int lines);
        for (int r = 0; r < lines; r++) begin
            for (int c = 0; c < width; c++) begin
                pixels[r][c] = $random(seed);
            end
        end
    endtask

    // Column c weighted 1,2,1 from row r-2 down to row r
    function automatic int columnSum(input int r, input int c);
        return int'(pixels[r-2][c]) + 2 * int'(pixels[r-1][c]) + int'(pixels[r][c]);
    endfunction

    task automatic modelFrame(input int width, input int lines);
        int                grad;
        int                lane;
        sobelPkg::busWordT word;
        expWords.delete();
        for (int r = 2; r < lines; r++) begin
            lane = 0;
            word = '0;
            for (int c = 2; c < width; c++) begin
                grad = columnSum(r, c) - columnSum(r, c - 2);
                if (grad < 0) begin
                    grad = -grad;
                end
                if (grad > 255) begin
                    grad = 255;
                end
                word[8*lane +: 8] = grad[7:0];
                lane++;
                if (lane == 4) begin
                    expWords.push_back(word);
                    lane = 0;
                    word = '0;
                end
            end
        end
    endtask

    task automatic feedFrame(input int width, input int lines);
        vsync = 1'b1;
        step();
        vsync = 1'b0;
        for (int r = 0; r < lines; r++) begin
            hsync = 1'b1;
            step();
            hsync = 1'b0;
            for (int c = 0; c < width; c++) begin
                validCamera = 1'b1;
                camData     = pixels[r][c];
                step();
            end
            validCamera = 1'b0;
            camData     = '0;
            repeat (3) step();
        end
    endtask

    // Grants one request and collects the burst until its end pulse
    task automatic serveBurst(input bit randomBusy);
        int n;
        waitFor(sigRequest, "requestBus never rose");
        busGrant = 1'b1;
        step();
        busGrant = 1'b0;
        n = 0;
        while (!endTransactionOut) begin
            if (n == waitLimit) begin
                failRun("burst never ended with endTransactionOut");
            end
            if (beginTransactionOut) begin
                gotAddrs.push_back(addressDataOut);
                gotSizes.push_back(sobelPkg::busWordT'(burstSizeOut));
                checkWord("byte enables", sobelPkg::busWordT'(byteEnablesOut), 32'hf);
            end
            busyIn = randomBusy && (($random(seed) & 1) == 1);
            if (dataValidOut && !busyIn) begin
                gotWords.push_back(addressDataOut);
            end
            step();
            n++;
        end
        busyIn = 1'b0;
        step();
    endtask

    task automatic runFrame(input bit randomBusy);
        gotWords.delete();
        gotAddrs.delete();
        gotSizes.delete();
        feedFrame(frameWidth, frameLines);
        repeat (expWords.size() / burstWords) serveBurst(randomBusy);
    endtask

    task automatic checkFrame();
        checkWord("word count", gotWords.size(), expWords.size());
        for (int i = 0; i < expWords.size() && i < gotWords.size(); i++) begin
            checkWord($sformatf("data word %0d", i), gotWords[i], expWords[i]);
        end
        checkWord("burst count", gotAddrs.size(), expWords.size() / burstWords);
        for (int i = 0; i < gotAddrs.size(); i++) begin
            checkWord($sformatf("burst %0d address", i), gotAddrs[i],
                      baseAddr + i * burstWords * wordBytes);
            checkWord($sformatf("burst %0d size", i), gotSizes[i], burstWords - 1);
        end
    endtask

    task automatic endTest(input string name, input int startErrors);
        testCount++;
        if (errorCount == startErrors) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errorCount - startErrors);
        end
    endtask

    task automatic testRegisters();
        int                startErrors;
        sobelPkg::busWordT value;
        logic              done;
        startErrors = errorCount;
        applyReset();
        configure(baseAddr, burstWords, 1'b1);
        readReg(sobelPkg::regBusStart, value);
        checkWord("busStart readback", value, baseAddr);
        readReg(sobelPkg::regBurstLen, value);
        checkWord("burstLen readback", value, burstWords);
        readReg(sobelPkg::regTransferEnable, value);
        checkWord("transferEnable readback", value, 32'd1);
        readReg(sobelPkg::regNone, value);
        checkWord("empty select readback", value, '0);
        readReg(sobelPkg::regStatus, value);
        checkStatus(value, '0);
        ciAccess(sobelPkg::customId + 8'd1, sobelPkg::regBusStart, 1'b0, '0, value, done);
        checkFlag("ciDone for foreign ciN", done, 1'b0);
        checkWord("ciResult for foreign ciN", value, '0);
        endTest("register access", startErrors);
    endtask

    task automatic testGradientFrame();
        int startErrors;
        startErrors = errorCount;
        applyReset();
        configure(baseAddr, burstWords, 1'b1);
        fillFrame(frameWidth, frameLines);
        modelFrame(frameWidth, frameLines);
        runFrame(1'b0);
        checkFrame();
        endTest("gradient frame", startErrors);
    endtask

    // Same pixels as the unstalled frame
    task automatic testBackPressure();
        int startErrors;
        startErrors = errorCount;
        applyReset();
        configure(baseAddr, burstWords, 1'b1);
        runFrame(1'b1);
        checkFrame();
        endTest("back-pressure", startErrors);
    endtask

    task automatic testBusError();
        int                startErrors;
        sobelPkg::busWordT value;
        startErrors = errorCount;
        applyReset();
        configure(baseAddr, burstWords, 1'b1);
        fillFrame(frameWidth, frameLines);
        feedFrame(frameWidth, frameLines);
        waitFor(sigRequest, "requestBus never rose");
        busGrant = 1'b1;
        step();
        busGrant = 1'b0;
        waitFor(sigBegin, "beginTransactionOut never pulsed");
        busErrorIn = 1'b1;
        step();
        busErrorIn = 1'b0;
        waitFor(sigEnd, "endTransactionOut never followed the bus error");
        repeat (2) step();
        readReg(sobelPkg::regStatus, value);
        checkStatus(value, 32'h1);
        writeReg(sobelPkg::regStatus, '0);
        readReg(sobelPkg::regStatus, value);
        checkStatus(value, '0);
        endTest("bus error", startErrors);
    endtask

    // 66 wide, 7 lines gives 80 words into a 64 word FIFO
    task automatic testOverflow();
        int                startErrors;
        sobelPkg::busWordT value;
        startErrors = errorCount;
        applyReset();
        configure(baseAddr, burstWords, 1'b0);
        fillFrame(66, 7);
        feedFrame(66, 7);
        repeat (4) step();
        readReg(sobelPkg::regStatus, value);
        checkStatus(value, 32'h2);
        endTest("overflow", startErrors);
    endtask

    task automatic testFrameRestart();
        int startErrors;
        startErrors = errorCount;
        applyReset();
        configure(baseAddr, burstWords, 1'b1);
        fillFrame(frameWidth, frameLines);
        modelFrame(frameWidth, frameLines);
        runFrame(1'b0);
        checkFrame();
        fillFrame(frameWidth, frameLines);
        modelFrame(frameWidth, frameLines);
        runFrame(1'b0);
        if (gotAddrs.size() > 0) begin
            checkWord("second frame first address", gotAddrs[0], baseAddr);
        end
        checkFrame();
        endTest("frame restart", startErrors);
    endtask

    initial begin
        seed        = 32'h4023_91c9;
        errorCount  = 0;
        checkCount  = 0;
        testCount   = 0;
        camClock    = 1'b0;
        rstN        = 1'b0;
        hsync       = 1'b0;
        vsync       = 1'b0;
        validCamera = 1'b0;
        camData     = '0;
        ciStart     = 1'b0;
        ciN         = 8'd0;
        ciValueA    = '0;
        ciValueB    = '0;
        busGrant    = 1'b0;
        busyIn      = 1'b0;
        busErrorIn  = 1'b0;
        testRegisters();
        testGradientFrame();
        testBackPressure();
        testBusError();
        testOverflow();
        testFrameRestart();
        $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
sobelPkg.sv
sobelConfigRegs.sv
sobelWindowFilter.sv
sobelWordFifo.sv
sobelBurstWriter.sv
sobelAccelerator.sv
tbSobelAccelerator.sv
